// ==== project.f ====
+incdir+rtl
+incdir+verif
rtl/pcxt_sys_pkg.sv
rtl/pcxt_video_pkg.sv
rtl/pcxt_reset_ctrl.sv
rtl/pcxt_video_out.sv
rtl/pcxt_activity_led.sv
rtl/pcxt_sd_select.sv
rtl/pcxt_shell.sv
verif/tb_pcxt_shell.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the PC/XT shell testbench with Verilator and runs it
# Exit status is 0 only when the testbench reports success

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f project.f --top-module tb_pcxt_shell
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_pcxt_shell)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
	exit 0
fi
exit 1

// ==== verif/tb_pcxt_vectors.svh ====
////////////////////////////////////////
// Video palette vectors for the PC/XT shell testbench
// Columns: mode, core r g b (6 bit), expected VGA r g b (8 bit)
// Expected luma is (54R + 183G + 18B) / 256, then two zero bits
////////////////////////////////////////

typedef struct packed {
	pcxt_sys_pkg::video_mode_e           mode;
	logic [`PCXT_CORE_COLOR_W-1:0]       r;
	logic [`PCXT_CORE_COLOR_W-1:0]       g;
	logic [`PCXT_CORE_COLOR_W-1:0]       b;
	logic [`PCXT_VGA_COLOR_W-1:0]        exp_r;
	logic [`PCXT_VGA_COLOR_W-1:0]        exp_g;
	logic [`PCXT_VGA_COLOR_W-1:0]        exp_b;
} video_vec_t;

localparam int NUM_VECTORS = 10;

video_vec_t video_table [NUM_VECTORS] = '{
	// Color passes straight through
	'{pcxt_sys_pkg::video_color, 6'h3F, 6'h00, 6'h15, 8'hFC, 8'h00, 8'h54},
	'{pcxt_sys_pkg::video_color, 6'h01, 6'h2A, 6'h3F, 8'h04, 8'hA8, 8'hFC},
	// Green, luma 62 and 29
	'{pcxt_sys_pkg::video_green, 6'h3F, 6'h3F, 6'h3F, 8'h00, 8'hF8, 8'h00},
	'{pcxt_sys_pkg::video_green, 6'h10, 6'h20, 6'h30, 8'h00, 8'h74, 8'h00},
	// Amber, green at half luma
	'{pcxt_sys_pkg::video_amber, 6'h3F, 6'h3F, 6'h3F, 8'hF8, 8'h7C, 8'h00},
	'{pcxt_sys_pkg::video_amber, 6'h00, 6'h3F, 6'h00, 8'hB4, 8'h58, 8'h00},
	'{pcxt_sys_pkg::video_amber, 6'h20, 6'h10, 6'h08, 8'h48, 8'h24, 8'h00},
	// Mono, luma 13, 4 and 0
	'{pcxt_sys_pkg::video_mono,  6'h3F, 6'h00, 6'h00, 8'h34, 8'h34, 8'h34},
	'{pcxt_sys_pkg::video_mono,  6'h00, 6'h00, 6'h3F, 8'h10, 8'h10, 8'h10},
	'{pcxt_sys_pkg::video_mono,  6'h00, 6'h00, 6'h00, 8'h00, 8'h00, 8'h00}
};

// ==== verif/tb_pcxt_shell.sv ====
////////////////////////////////////////
// Testbench for the PC/XT shell glue logic
// Runs splash, reset, video, aspect, LED and SD routing sequences
// Short timers keep the splash at 100 cycles and the LED at 8
////////////////////////////////////////

`include "pcxt_settings.svh"

module tb_pcxt_shell;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TICKS         = 20;
	localparam int LED_HOLD      = 8;
	localparam int SPLASH_CYCLES = `PCXT_SPLASH_SECONDS * TICKS;
	localparam int MAX_CYCLES    = 2000;

	logic                        CLK_50M = 1'b0;
	logic                        arst_n;
	pcxt_sys_pkg::osd_status_t   status;
	logic                        btn_reset;
	logic                        img_mounted;
	pcxt_sys_pkg::img_size_t     img_size;
	logic                        floppy_cs;
	pcxt_video_pkg::core_pixel_t pix_in;
	pcxt_sys_pkg::spi_t          core_spi;
	logic                        sd_miso;
	logic                        image_miso;
	logic                        splash;
	logic                        core_reset;
	pcxt_video_pkg::vga_pixel_t  pix_out;
	logic [`PCXT_AR_W-1:0]       arx;
	logic [`PCXT_AR_W-1:0]       ary;
	logic                        led_user;
	pcxt_sys_pkg::spi_t          sd_spi;
	logic                        image_cs;
	logic                        core_miso;

	int seed      = 21814;
	int errors    = 0;
	int checks    = 0;
	int cycle_cnt = 0;

	`include "tb_pcxt_vectors.svh"

	pcxt_shell #(
		.TICKS_PER_SECOND(TICKS),
		.LED_HOLD        (LED_HOLD)
	) pcxt_shell_i (
		.CLK_50M    (CLK_50M),
		.arst_n     (arst_n),
		.status     (status),
		.btn_reset  (btn_reset),
		.img_mounted(img_mounted),
		.img_size   (img_size),
		.floppy_cs  (floppy_cs),
		.pix_in     (pix_in),
		.core_spi   (core_spi),
		.sd_miso    (sd_miso),
		.image_miso (image_miso),
		.splash     (splash),
		.core_reset (core_reset),
		.pix_out    (pix_out),
		.arx        (arx),
		.ary        (ary),
		.led_user   (led_user),
		.sd_spi     (sd_spi),
		.image_cs   (image_cs),
		.core_miso  (core_miso)
	);

	// 50 MHz clock
	always #10 CLK_50M = ~CLK_50M;

	// Run limit
	always @(posedge CLK_50M) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAIL %s expected %0h got %0h at %0t", name, expected, actual, $time);
		end
	endtask

	// Luma rule, weights in 1/256, truncated
	function automatic logic [5:0] luma_of(input logic [5:0] r, input logic [5:0] g,
		input logic [5:0] b);
		int sum;
		sum = 54 * int'(r) + 183 * int'(g) + 18 * int'(b);
		return 6'(sum / 256);
	endfunction

	// hs, vs and de pattern tied to the vector index
	function automatic logic [2:0] sync_of(input int i);
		return 3'(i);
	endfunction

	task automatic apply_reset(input logic skip);
		@(negedge CLK_50M);
		arst_n = 1'b0;
		status.skip_splash = skip;
		repeat (10) @(negedge CLK_50M);
		arst_n = 1'b1;
	endtask

	// Source 0 is reset_req, 1 is btn_reset, others img_mounted
	task automatic pulse_reset_source(input int src, input logic expect_reset);
		@(negedge CLK_50M);
		case (src)
			0: status.reset_req = 1'b1;
			1: btn_reset = 1'b1;
			default: img_mounted = 1'b1;
		endcase
		@(negedge CLK_50M);
		status.reset_req = 1'b0;
		btn_reset = 1'b0;
		img_mounted = 1'b0;
		check_value("core_reset", expect_reset, core_reset);
		@(negedge CLK_50M);
		check_value("core_reset", 0, core_reset);
	endtask

	task automatic run_video_table();
		int i;
		for (i = 0; i <= NUM_VECTORS; i++) begin
			@(negedge CLK_50M);
			// Output shows the vector driven one cycle ago
			if (i > 0) begin
				check_value("pix_out.r", video_table[i-1].exp_r, pix_out.r);
				check_value("pix_out.g", video_table[i-1].exp_g, pix_out.g);
				check_value("pix_out.b", video_table[i-1].exp_b, pix_out.b);
				check_value("pix_out.sync", sync_of(i - 1),
					{pix_out.hs, pix_out.vs, pix_out.de});
			end
			if (i < NUM_VECTORS) begin
				status.video_mode = video_table[i].mode;
				pix_in.r = video_table[i].r;
				pix_in.g = video_table[i].g;
				pix_in.b = video_table[i].b;
				{pix_in.hs, pix_in.vs, pix_in.de} = sync_of(i);
			end
		end
	endtask

	task automatic run_mono_random(input int count);
		int i;
		logic [31:0] rnd;
		logic [7:0] exp_grey;
		exp_grey = '0;
		status.video_mode = pcxt_sys_pkg::video_mono;
		for (i = 0; i <= count; i++) begin
			@(negedge CLK_50M);
			if (i > 0) begin
				check_value("pix_out.r", exp_grey, pix_out.r);
				check_value("pix_out.g", exp_grey, pix_out.g);
				check_value("pix_out.b", exp_grey, pix_out.b);
			end
			rnd = $random(seed);
			pix_in.r = rnd[5:0];
			pix_in.g = rnd[11:6];
			pix_in.b = rnd[17:12];
			// Two zero bits appended on widening
			exp_grey = {luma_of(pix_in.r, pix_in.g, pix_in.b), 2'b00};
		end
	endtask

	task automatic mount_image(input logic [63:0] size);
		@(negedge CLK_50M);
		img_mounted = 1'b1;
		img_size = size;
		@(negedge CLK_50M);
		img_mounted = 1'b0;
	endtask

	// All SPI combinations, MISO lines random
	task automatic check_sd_route(input logic image_active);
		int n;
		logic [31:0] rnd;
		for (n = 0; n < 8; n++) begin
			@(negedge CLK_50M);
			{core_spi.cs, core_spi.sck, core_spi.mosi} = 3'(n);
			rnd = $random(seed);
			sd_miso = rnd[0];
			image_miso = rnd[1];
			#5;
			if (image_active) begin
				check_value("sd_spi", 3'b100, sd_spi);
				check_value("core_miso", image_miso, core_miso);
				check_value("image_cs", core_spi.cs, image_cs);
			end else begin
				check_value("sd_spi", core_spi, sd_spi);
				check_value("core_miso", sd_miso, core_miso);
				check_value("image_cs", 1, image_cs);
			end
		end
	endtask

	////////////////////////////////////////
	// Sequences
	////////////////////////////////////////

	initial begin
		int i;
		int a;
		arst_n = 1'b0;
		status = '0;
		btn_reset = 1'b0;
		img_mounted = 1'b0;
		img_size = '0;
		floppy_cs = 1'b0;
		pix_in = '0;
		core_spi = '0;
		core_spi.cs = 1'b1;
		sd_miso = 1'b0;
		image_miso = 1'b0;

		// Full splash, core held in reset throughout
		apply_reset(1'b0);
		for (i = 1; i < SPLASH_CYCLES; i++) begin
			@(negedge CLK_50M);
			check_value("splash", 1, splash);
			check_value("core_reset", 1, core_reset);
		end
		@(negedge CLK_50M);
		check_value("splash", 0, splash);
		check_value("core_reset", 1, core_reset);
		@(negedge CLK_50M);
		check_value("core_reset", 0, core_reset);

		// Skipped splash
		apply_reset(1'b1);
		@(negedge CLK_50M);
		check_value("splash", 0, splash);
		check_value("core_reset", 1, core_reset);
		@(negedge CLK_50M);
		check_value("core_reset", 0, core_reset);

		// Reset sources, mount only with reset_on_mount
		pulse_reset_source(0, 1'b1);
		pulse_reset_source(1, 1'b1);
		status.reset_on_mount = 1'b1;
		pulse_reset_source(2, 1'b1);
		status.reset_on_mount = 1'b0;
		pulse_reset_source(2, 1'b0);

		run_video_table();
		run_mono_random(16);

		// Aspect ratio outputs
		for (a = 0; a < 4; a++) begin
			@(negedge CLK_50M);
			status.aspect = pcxt_sys_pkg::aspect_e'(a);
			@(negedge CLK_50M);
			check_value("arx", (a == 0) ? 4 : a - 1, arx);
			check_value("ary", (a == 0) ? 3 : 0, ary);
		end

		// Single floppy access
		@(negedge CLK_50M);
		check_value("led_user", 0, led_user);
		floppy_cs = 1'b1;
		for (i = 1; i <= LED_HOLD; i++) begin
			@(negedge CLK_50M);
			floppy_cs = 1'b0;
			check_value("led_user", 1, led_user);
		end
		@(negedge CLK_50M);
		check_value("led_user", 0, led_user);

		// Second access inside the hold extends it
		floppy_cs = 1'b1;
		for (i = 1; i <= 4; i++) begin
			@(negedge CLK_50M);
			check_value("led_user", 1, led_user);
			floppy_cs = (i == 4);
		end
		for (i = 1; i <= LED_HOLD; i++) begin
			@(negedge CLK_50M);
			floppy_cs = 1'b0;
			check_value("led_user", 1, led_user);
		end
		@(negedge CLK_50M);
		check_value("led_user", 0, led_user);

		// SD routing, physical card, image, then back
		check_sd_route(1'b0);
		mount_image(64'h0010_0000);
		check_sd_route(1'b1);
		mount_image(64'h0);
		check_sd_route(1'b0);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== rtl/pcxt_shell.sv ====
////////////////////////////////////////
// Top level of the PC/XT glue logic
// Reset and splash control, video output, floppy LED and
// SD card routing, all on CLK_50M
////////////////////////////////////////

`include "pcxt_settings.svh"

module pcxt_shell #(
	parameter int TICKS_PER_SECOND = `PCXT_TICKS_PER_SECOND,
	parameter int LED_HOLD         = `PCXT_LED_HOLD
) (
	input  logic                        CLK_50M,
	input  logic                        arst_n,
	input  pcxt_sys_pkg::osd_status_t   status,
	input  logic                        btn_reset,
	input  logic                        img_mounted,
	input  pcxt_sys_pkg::img_size_t     img_size,
	input  logic                        floppy_cs,
	input  pcxt_video_pkg::core_pixel_t pix_in,
	input  pcxt_sys_pkg::spi_t          core_spi,
	input  logic                        sd_miso,
	input  logic                        image_miso,
	output logic                        splash,
	output logic                        core_reset,
	output pcxt_video_pkg::vga_pixel_t  pix_out,
	output logic [`PCXT_AR_W-1:0]       arx,
	output logic [`PCXT_AR_W-1:0]       ary,
	output logic                        led_user,
	output pcxt_sys_pkg::spi_t          sd_spi,
	output logic                        image_cs,
	output logic                        core_miso
);

	// Splash timer and combined reset
	pcxt_reset_ctrl #(
		.TICKS_PER_SECOND(TICKS_PER_SECOND)
	) reset_ctrl_i (
		.CLK_50M    (CLK_50M),
		.arst_n     (arst_n),
		.status     (status),
		.btn_reset  (btn_reset),
		.img_mounted(img_mounted),
		.splash     (splash),
		.core_reset (core_reset)
	);

	// Palette and aspect from the OSD fields
	pcxt_video_out video_out_i (
		.CLK_50M(CLK_50M),
		.arst_n (arst_n),
		.mode   (status.video_mode),
		.aspect (status.aspect),
		.pix_in (pix_in),
		.pix_out(pix_out),
		.arx    (arx),
		.ary    (ary)
	);

	pcxt_activity_led #(
		.HOLD(LED_HOLD)
	) activity_led_i (
		.CLK_50M  (CLK_50M),
		.arst_n   (arst_n),
		.floppy_cs(floppy_cs),
		.led      (led_user)
	);

	pcxt_sd_select sd_select_i (
		.CLK_50M    (CLK_50M),
		.arst_n     (arst_n),
		.img_mounted(img_mounted),
		.img_size   (img_size),
		.core_spi   (core_spi),
		.sd_spi     (sd_spi),
		.sd_miso    (sd_miso),
		.image_cs   (image_cs),
		.image_miso (image_miso),
		.core_miso  (core_miso)
	);

endmodule

// ==== rtl/pcxt_sd_select.sv ====
////////////////////////////////////////
// SD card routing for the PC/XT shell
// A mounted VHD image takes over the SPI from the physical card
// Unmounting, or a zero-size mount, hands the card back
////////////////////////////////////////

module pcxt_sd_select (
	input  logic                    CLK_50M,
	input  logic                    arst_n,
	input  logic                    img_mounted,
	input  pcxt_sys_pkg::img_size_t img_size,
	input  pcxt_sys_pkg::spi_t      core_spi,
	output pcxt_sys_pkg::spi_t      sd_spi,
	input  logic                    sd_miso,
	output logic                    image_cs,
	input  logic                    image_miso,
	output logic                    core_miso
);

	// Set while the virtual image serves the core
	logic img_used;

	always_ff @(posedge CLK_50M or negedge arst_n) begin
		if (!arst_n)
			img_used <= 1'b0;
		else if (img_mounted)
			img_used <= (img_size != '0);
	end

	////////////////////////////////////////
	// SPI steering
	////////////////////////////////////////

	// Physical card parked deselected with a quiet bus
	assign sd_spi.cs   = core_spi.cs | img_used;
	assign sd_spi.sck  = core_spi.sck & ~img_used;
	assign sd_spi.mosi = core_spi.mosi & ~img_used;

	// Image only sees chip select when in use
	assign image_cs = core_spi.cs | ~img_used;

	assign core_miso = img_used ? image_miso : sd_miso;

	// Card is released from the cycle after a nonzero mount
	a_card_parked: assert property (
		@(posedge CLK_50M) disable iff (!arst_n)
		(img_mounted && img_size != '0) |=> sd_spi.cs
	);

endmodule

// ==== rtl/pcxt_activity_led.sv ====
////////////////////////////////////////
// Floppy activity LED
// Short chip-select pulses are stretched so the LED is visible
////////////////////////////////////////

`include "pcxt_settings.svh"

module pcxt_activity_led #(
	parameter int HOLD = `PCXT_LED_HOLD
) (
	input  logic CLK_50M,
	input  logic arst_n,
	input  logic floppy_cs,
	output logic led
);

	localparam int CNT_W = $clog2(HOLD + 1);

	logic [CNT_W-1:0] hold_cnt;
	logic [CNT_W-1:0] hold_next;

	// Each access restarts the afterglow
	always_comb begin
		if (floppy_cs)
			hold_next = CNT_W'(HOLD);
		else if (hold_cnt != '0)
			hold_next = hold_cnt - 1'b1;
		else
			hold_next = '0;
	end

	always_ff @(posedge CLK_50M or negedge arst_n) begin
		if (!arst_n) begin
			hold_cnt <= '0;
			led      <= 1'b0;
		end else begin
			hold_cnt <= hold_next;
			led      <= (hold_next != '0);
		end
	end

	// Hold expired and no new access, LED goes dark
	a_led_off: assert property (
		@(posedge CLK_50M) disable iff (!arst_n)
		(hold_cnt == '0 && !floppy_cs) |=> !led
	);

endmodule

// ==== rtl/pcxt_video_out.sv ====
////////////////////////////////////////
// Video output stage of the PC/XT shell
// Applies the monochrome palette, widens to 8-bit channels and
// registers the pixel with its syncs. One cycle latency
// Also drives the HDMI aspect-ratio outputs
////////////////////////////////////////

`include "pcxt_settings.svh"

module pcxt_video_out (
	input  logic                        CLK_50M,
	input  logic                        arst_n,
	input  pcxt_sys_pkg::video_mode_e   mode,
	input  pcxt_sys_pkg::aspect_e       aspect,
	input  pcxt_video_pkg::core_pixel_t pix_in,
	output pcxt_video_pkg::vga_pixel_t  pix_out,
	output logic [`PCXT_AR_W-1:0]       arx,
	output logic [`PCXT_AR_W-1:0]       ary
);

	localparam int CW    = `PCXT_CORE_COLOR_W;
	localparam int VW    = `PCXT_VGA_COLOR_W;
	localparam int AR_W  = `PCXT_AR_W;
	// Weights in 1/256, about 0.2126, 0.7152 and 0.0722
	localparam int KR    = 54;
	localparam int KG    = 183;
	localparam int KB    = 18;
	localparam int SUM_W = CW + 8;

	logic [SUM_W-1:0]           luma_sum;
	logic [CW-1:0]              luma;
	logic [CW-1:0]              r_mix;
	logic [CW-1:0]              g_mix;
	logic [CW-1:0]              b_mix;
	pcxt_video_pkg::vga_pixel_t pix_next;

	////////////////////////////////////////
	// Luma and palette
	////////////////////////////////////////

	// Weights sum to 255, so the sum never overflows SUM_W
	assign luma_sum = SUM_W'(KR) * SUM_W'(pix_in.r)
		+ SUM_W'(KG) * SUM_W'(pix_in.g)
		+ SUM_W'(KB) * SUM_W'(pix_in.b);
	// Divide by 256, truncated
	assign luma = luma_sum[SUM_W-1:8];

	always_comb begin
		case (mode)
			pcxt_sys_pkg::video_green: begin
				r_mix = '0;
				g_mix = luma;
				b_mix = '0;
			end
			pcxt_sys_pkg::video_amber: begin
				// Amber phosphor, green at half strength
				r_mix = luma;
				g_mix = luma >> 1;
				b_mix = '0;
			end
			pcxt_sys_pkg::video_mono: begin
				r_mix = luma;
				g_mix = luma;
				b_mix = luma;
			end
			default: begin
				r_mix = pix_in.r;
				g_mix = pix_in.g;
				b_mix = pix_in.b;
			end
		endcase
	end

	// Widen by zero fill in the low bits
	always_comb begin
		pix_next.r  = {r_mix, {(VW - CW){1'b0}}};
		pix_next.g  = {g_mix, {(VW - CW){1'b0}}};
		pix_next.b  = {b_mix, {(VW - CW){1'b0}}};
		pix_next.hs = pix_in.hs;
		pix_next.vs = pix_in.vs;
		pix_next.de = pix_in.de;
	end

	// Colors and syncs share one register, so they stay aligned
	always_ff @(posedge CLK_50M or negedge arst_n) begin
		if (!arst_n)
			pix_out <= '0;
		else
			pix_out <= pix_next;
	end

	////////////////////////////////////////
	// Aspect ratio
	////////////////////////////////////////

	// Original is 4:3, other codes select scaler presets 0..2
	assign arx = (aspect == pcxt_sys_pkg::aspect_original) ?
		AR_W'(4) : AR_W'(aspect) - AR_W'(1);
	assign ary = (aspect == pcxt_sys_pkg::aspect_original) ? AR_W'(3) : '0;

	// Grey output one cycle after a mono pixel enters
	a_mono_grey: assert property (
		@(posedge CLK_50M) disable iff (!arst_n)
		(mode == pcxt_sys_pkg::video_mono) |=>
			(pix_out.r == pix_out.g) && (pix_out.g == pix_out.b)
	);

endmodule

// ==== rtl/pcxt_reset_ctrl.sv ====
////////////////////////////////////////
// Splash-screen timer and core reset for the PC/XT shell
// splash holds the core in reset for a few seconds after power-up
// unless the OSD asks to skip it. core_reset combines all sources
////////////////////////////////////////

`include "pcxt_settings.svh"

module pcxt_reset_ctrl #(
	parameter int TICKS_PER_SECOND = `PCXT_TICKS_PER_SECOND
) (
	input  logic                      CLK_50M,
	input  logic                      arst_n,
	input  pcxt_sys_pkg::osd_status_t status,
	input  logic                      btn_reset,
	input  logic                      img_mounted,
	output logic                      splash,
	output logic                      core_reset
);

	localparam int SECONDS = `PCXT_SPLASH_SECONDS;
	localparam int TICK_W  = $clog2(TICKS_PER_SECOND);
	localparam int SEC_W   = $clog2(SECONDS + 1);

	logic [TICK_W-1:0] tick_cnt;
	logic [SEC_W-1:0]  sec_cnt;
	logic              reset_src;

	////////////////////////////////////////
	// Splash timer
	////////////////////////////////////////

	// Counters run only while the splash is shown
	always_ff @(posedge CLK_50M or negedge arst_n) begin
		if (!arst_n) begin
			tick_cnt <= '0;
			sec_cnt  <= '0;
			splash   <= 1'b1;
		end else if (splash) begin
			if (status.skip_splash) begin
				// OSD option "Splash Screen: No"
				splash <= 1'b0;
			end else if (tick_cnt == TICK_W'(TICKS_PER_SECOND - 1)) begin
				tick_cnt <= '0;
				sec_cnt  <= sec_cnt + 1'b1;
				// Last second just ended
				if (sec_cnt == SEC_W'(SECONDS - 1))
					splash <= 1'b0;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Core reset
	////////////////////////////////////////

	// Mount only resets when the OSD option asks for it
	assign reset_src = status.reset_req
		| btn_reset
		| (status.reset_on_mount & img_mounted)
		| splash;

	always_ff @(posedge CLK_50M or negedge arst_n) begin
		if (!arst_n)
			core_reset <= 1'b1;
		else
			core_reset <= reset_src;
	end

	// Core never runs while the splash screen is up
	a_splash_holds_reset: assert property (
		@(posedge CLK_50M) disable iff (!arst_n)
		splash |=> core_reset
	);

endmodule

// ==== rtl/pcxt_video_pkg.sv ====
////////////////////////////////////////
// Pixel types of the PC/XT video path
// Core pixels enter at 6 bits per channel
// VGA pixels leave at 8 bits per channel
////////////////////////////////////////

`include "pcxt_settings.svh"

package pcxt_video_pkg;

	// Pixel as produced by the CGA core
	typedef struct packed {
		logic [`PCXT_CORE_COLOR_W-1:0] r;
		logic [`PCXT_CORE_COLOR_W-1:0] g;
		logic [`PCXT_CORE_COLOR_W-1:0] b;
		logic                          hs;
		logic                          vs;
		// Active video, low in blanking
		logic                          de;
	} core_pixel_t;

	// Pixel as sent to the video output
	typedef struct packed {
		logic [`PCXT_VGA_COLOR_W-1:0] r;
		logic [`PCXT_VGA_COLOR_W-1:0] g;
		logic [`PCXT_VGA_COLOR_W-1:0] b;
		logic                         hs;
		logic                         vs;
		logic                         de;
	} vga_pixel_t;

endpackage

// ==== rtl/pcxt_sys_pkg.sv ====
////////////////////////////////////////
// System-side types of the PC/XT shell
// OSD menu settings and SD card SPI signals
// Referenced by scoped name only
////////////////////////////////////////

package pcxt_sys_pkg;

	// Monochrome monitor emulation, OSD "Video" entry
	typedef enum logic [1:0] {
		video_color = 2'd0,
		video_green = 2'd1,
		video_amber = 2'd2,
		video_mono  = 2'd3
	} video_mode_e;

	// OSD "Aspect ratio" entry
	typedef enum logic [1:0] {
		aspect_original = 2'd0,
		aspect_full     = 2'd1,
		aspect_arc1     = 2'd2,
		aspect_arc2     = 2'd3
	} aspect_e;

	// Decoded OSD status word
	typedef struct packed {
		logic        reset_req;
		logic        skip_splash;
		logic        reset_on_mount;
		video_mode_e video_mode;
		aspect_e     aspect;
	} osd_status_t;

	// Size of a mounted image in bytes, zero on unmount
	typedef logic [63:0] img_size_t;

	// SPI master side, chip select active low
	typedef struct packed {
		logic cs;
		logic sck;
		logic mosi;
	} spi_t;

endpackage

// ==== rtl/pcxt_settings.svh ====
////////////////////////////////////////
// Timing and width constants for the PC/XT shell
// Include this where counters or color channels are sized
// The include guard allows repeated inclusion in one unit
////////////////////////////////////////

`ifndef PCXT_SETTINGS_SVH
`define PCXT_SETTINGS_SVH

////////////////////////////////////////
// Timers, counted in CLK_50M cycles
////////////////////////////////////////

// One second of CLK_50M
`define PCXT_TICKS_PER_SECOND 50000000
// Splash screen length in seconds
`define PCXT_SPLASH_SECONDS 5
// LED afterglow following a floppy access, about 90 ms
`define PCXT_LED_HOLD 4500000

////////////////////////////////////////
// Video widths
////////////////////////////////////////

// Color channel width coming out of the CGA core
`define PCXT_CORE_COLOR_W 6
// Color channel width at the VGA/HDMI output
`define PCXT_VGA_COLOR_W 8
// Aspect-ratio bus width, bit 12 flags a scaled size
`define PCXT_AR_W 13

`endif
